// File: design/wisc_defs.svh
// sizing macros for the WISC core, included by the package and every RTL file
// that needs a width
`ifndef WISC_DEFS_SVH
`define WISC_DEFS_SVH

// datapath word
`define WISC_WORD_W 16

// architectural registers, R7 takes the link
`define WISC_NREGS 8

// word-addressed memories
`define WISC_IADDR_W 8
`define WISC_DADDR_W 8

`endif

// File: design/wiscPkg.sv
// shared types of the WISC core: words, instruction layout, opcodes and
// the control bundle passed from the decoder to the datapath
`include "wisc_defs.svh"

package wiscPkg;

   typedef logic [`WISC_WORD_W-1:0] wordT;

   // 11001 (btr) is left unnamed, the decoder treats it as illegal
   typedef enum logic [4:0] {
      opHalt  = 5'b00000, opNop   = 5'b00001, opSiic  = 5'b00010, opRti   = 5'b00011,
      opJ     = 5'b00100, opJr    = 5'b00101, opJal   = 5'b00110, opJalr  = 5'b00111,
      opAddi  = 5'b01000, opSubi  = 5'b01001, opXori  = 5'b01010, opAndni = 5'b01011,
      opBeqz  = 5'b01100, opBnez  = 5'b01101, opBltz  = 5'b01110, opBgez  = 5'b01111,
      opSt    = 5'b10000, opLd    = 5'b10001, opSlbi  = 5'b10010, opStu   = 5'b10011,
      opRoli  = 5'b10100, opSlli  = 5'b10101, opRori  = 5'b10110, opSrli  = 5'b10111,
      opLbi   = 5'b11000, opShift = 5'b11010, opAlu   = 5'b11011,
      opSeq   = 5'b11100, opSlt   = 5'b11101, opSle   = 5'b11110, opSco   = 5'b11111
   } opcodeT;

   typedef struct packed {
      opcodeT     opcode;
      logic [2:0] rs; // bits 10:8
      logic [2:0] rt; // bits 7:5, also dest of i-format
      logic [4:0] low; // imm5, or rd in 4:2 plus funct in 1:0
   } instrT;

   typedef enum logic [2:0] {
      aluAdd, aluXor, aluAnd, aluRol, aluSll, aluRor, aluSrl
   } aluOpT;

   typedef enum logic [2:0] {
      condNever, condZero, condNonZero, condSign,
      condNotSignOrZero, condSignOrZero, condCarry, condAlways
   } condT;

   typedef enum logic [1:0] {wbPcPlus, wbMem, wbAlu, wbImm8} wbSelT;

   typedef enum logic [1:0] {bReg, bImm5, bImm8, bZero} bSrcT;

   typedef enum logic [1:0] {destRs, destRt, destRd, destR7} destSelT;

   typedef struct packed {
      logic   regWrt;
      logic   memWrt;
      wbSelT  wbSel;
      bSrcT   bSrc;
      logic   zeroExt; // zero extend imm5/imm8, slbi path on imm8
      logic   invA;
      logic   invB;
      logic   cin;
      aluOpT  aluOp;
      condT   cond; // branch or set condition
      logic   setOp; // write cond bit instead of branching
      logic   jumpImm; // j, jal
      logic   jumpReg; // jr, jalr
      logic   link; // write pc+1 to r7
      logic   stuSel; // stu base update
      logic   halt;
   } ctrlT;

   typedef struct packed {
      logic zero;
      logic sign; // true sign, overflow corrected
      logic carry;
   } flagsT;

endpackage

// File: design/controlUnit.sv
// opcode decoder of the single-cycle core, purely combinational
// every field starts inactive and each opcode turns on what it needs
module controlUnit (
   input  wiscPkg::instrT instr,
   output wiscPkg::ctrlT  ctrl,
   output logic           illegal
);

   always_comb begin
      ctrl    = '0; // nop bundle, add with no writes
      illegal = 1'b0;
      case (instr.opcode)
         wiscPkg::opHalt: ctrl.halt = 1'b1;
         wiscPkg::opNop, wiscPkg::opSiic, wiscPkg::opRti: begin
            // no exceptions here, all three just fall through
         end
         wiscPkg::opAddi, wiscPkg::opSubi, wiscPkg::opXori, wiscPkg::opAndni: begin
            ctrl.regWrt = 1'b1;
            ctrl.wbSel  = wiscPkg::wbAlu;
            ctrl.bSrc   = wiscPkg::bImm5;
            ctrl.zeroExt = instr.opcode[1]; // xori, andni take zero ext
            case (instr.opcode[1:0])
               2'b01: begin // imm - rs
                  ctrl.invA = 1'b1;
                  ctrl.cin  = 1'b1;
               end
               2'b10: ctrl.aluOp = wiscPkg::aluXor;
               2'b11: begin
                  ctrl.aluOp = wiscPkg::aluAnd;
                  ctrl.invB  = 1'b1; // and with ~imm
               end
               default: ctrl.aluOp = wiscPkg::aluAdd;
            endcase
         end
         wiscPkg::opRoli, wiscPkg::opSlli, wiscPkg::opRori, wiscPkg::opSrli: begin
            ctrl.regWrt  = 1'b1;
            ctrl.wbSel   = wiscPkg::wbAlu;
            ctrl.bSrc    = wiscPkg::bImm5;
            ctrl.zeroExt = 1'b1; // shift amount never negative
            ctrl.aluOp   = wiscPkg::aluOpT'(3'd3 + {1'b0, instr.opcode[1:0]}); // rol..srl
         end
         wiscPkg::opAlu: begin
            ctrl.regWrt = 1'b1;
            ctrl.wbSel  = wiscPkg::wbAlu; // bSrc stays register
            case (instr.low[1:0]) // funct bits
               2'b01: begin // sub, rt - rs
                  ctrl.invA = 1'b1;
                  ctrl.cin  = 1'b1;
               end
               2'b10: ctrl.aluOp = wiscPkg::aluXor;
               2'b11: begin // andn
                  ctrl.aluOp = wiscPkg::aluAnd;
                  ctrl.invB  = 1'b1;
               end
               default: ctrl.aluOp = wiscPkg::aluAdd;
            endcase
         end
         wiscPkg::opShift: begin
            ctrl.regWrt = 1'b1;
            ctrl.wbSel  = wiscPkg::wbAlu;
            ctrl.aluOp  = wiscPkg::aluOpT'(3'd3 + {1'b0, instr.low[1:0]});
         end
         wiscPkg::opSt: begin
            ctrl.memWrt = 1'b1;
            ctrl.bSrc   = wiscPkg::bImm5; // rs + sext imm5
         end
         wiscPkg::opLd: begin
            ctrl.regWrt = 1'b1;
            ctrl.wbSel  = wiscPkg::wbMem;
            ctrl.bSrc   = wiscPkg::bImm5;
         end
         wiscPkg::opStu: begin
            ctrl.memWrt = 1'b1;
            ctrl.regWrt = 1'b1; // address back to rs
            ctrl.wbSel  = wiscPkg::wbAlu;
            ctrl.bSrc   = wiscPkg::bImm5;
            ctrl.stuSel = 1'b1;
         end
         wiscPkg::opSeq, wiscPkg::opSlt, wiscPkg::opSle: begin
            ctrl.regWrt = 1'b1;
            ctrl.wbSel  = wiscPkg::wbAlu;
            ctrl.setOp  = 1'b1;
            ctrl.invB   = 1'b1; // rs - rt
            ctrl.cin    = 1'b1;
            case (instr.opcode[1:0])
               2'b00:   ctrl.cond = wiscPkg::condZero;
               2'b01:   ctrl.cond = wiscPkg::condSign;
               default: ctrl.cond = wiscPkg::condSignOrZero;
            endcase
         end
         wiscPkg::opSco: begin
            ctrl.regWrt = 1'b1;
            ctrl.wbSel  = wiscPkg::wbAlu;
            ctrl.setOp  = 1'b1;
            ctrl.cond   = wiscPkg::condCarry; // carry of rs + rt
         end
         wiscPkg::opBeqz, wiscPkg::opBnez, wiscPkg::opBltz, wiscPkg::opBgez: begin
            ctrl.bSrc = wiscPkg::bZero; // flags of rs + 0
            case (instr.opcode[1:0])
               2'b00:   ctrl.cond = wiscPkg::condZero;
               2'b01:   ctrl.cond = wiscPkg::condNonZero;
               2'b10:   ctrl.cond = wiscPkg::condSign;
               default: ctrl.cond = wiscPkg::condNotSignOrZero;
            endcase
         end
         wiscPkg::opLbi: begin
            ctrl.regWrt = 1'b1;
            ctrl.wbSel  = wiscPkg::wbImm8; // sext imm8
         end
         wiscPkg::opSlbi: begin
            ctrl.regWrt  = 1'b1;
            ctrl.wbSel   = wiscPkg::wbImm8;
            ctrl.zeroExt = 1'b1; // rs << 8 | imm8
         end
         wiscPkg::opJ: ctrl.jumpImm = 1'b1;
         wiscPkg::opJal: begin
            ctrl.jumpImm = 1'b1;
            ctrl.regWrt  = 1'b1;
            ctrl.wbSel   = wiscPkg::wbPcPlus;
            ctrl.link    = 1'b1;
         end
         wiscPkg::opJr, wiscPkg::opJalr: begin
            ctrl.jumpReg = 1'b1; // target rs + sext imm8 from alu
            ctrl.bSrc    = wiscPkg::bImm8;
            ctrl.regWrt  = instr.opcode[1]; // jalr links
            ctrl.link    = instr.opcode[1];
            ctrl.wbSel   = wiscPkg::wbPcPlus;
         end
         default: illegal = 1'b1; // error stop
      endcase
   end

endmodule

// File: design/regFile.sv
// register file, two async read ports, one write port on the clock edge
// and a debug read port for the testbench
`include "wisc_defs.svh"

module regFile (
   input  logic          clk,
   input  logic          reset,
   input  logic [2:0]    rdAddrA,
   input  logic [2:0]    rdAddrB,
   output wiscPkg::wordT rdDataA,
   output wiscPkg::wordT rdDataB,
   input  logic          wrEn,
   input  logic [2:0]    wrAddr,
   input  wiscPkg::wordT wrData,
   input  logic [2:0]    dbgSel,
   output wiscPkg::wordT dbgData
);

   wiscPkg::wordT regs [`WISC_NREGS];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `WISC_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   assign rdDataA = regs[rdAddrA];
   assign rdDataB = regs[rdAddrB]; // also store data
   assign dbgData = regs[dbgSel];

endmodule

// File: design/alu.sv
// datapath ALU: adder with operand inversion and carry in, xor/and,
// rotates and logical shifts; flags always come from the adder
`include "wisc_defs.svh"

module alu (
   input  wiscPkg::wordT  a,
   input  wiscPkg::wordT  b,
   input  wiscPkg::ctrlT  ctrl,
   output wiscPkg::wordT  result,
   output wiscPkg::flagsT flags
);

   localparam int W = `WISC_WORD_W;

   wiscPkg::wordT aIn;
   wiscPkg::wordT bIn;
   wiscPkg::wordT sum;
   logic          cout;
   logic          ovf;
   logic [3:0]    shamt;
   logic [2*W-1:0] rolWide;
   logic [2*W-1:0] rorWide;

   assign aIn = ctrl.invA ? ~a : a; // sub forms
   assign bIn = ctrl.invB ? ~b : b; // andn, compares
   assign {cout, sum} = {1'b0, aIn} + {1'b0, bIn} + {{W{1'b0}}, ctrl.cin};

   assign ovf = (aIn[W-1] == bIn[W-1]) && (sum[W-1] != aIn[W-1]);

   assign shamt   = b[3:0]; // low four bits only
   assign rolWide = {a, a} << shamt; // upper half is the rotate
   assign rorWide = {a, a} >> shamt; // lower half is the rotate

   always_comb begin
      case (ctrl.aluOp)
         wiscPkg::aluXor: result = aIn ^ bIn;
         wiscPkg::aluAnd: result = aIn & bIn;
         wiscPkg::aluRol: result = rolWide[2*W-1:W];
         wiscPkg::aluSll: result = a << shamt;
         wiscPkg::aluRor: result = rorWide[W-1:0];
         wiscPkg::aluSrl: result = a >> shamt;
         default:         result = sum;
      endcase
   end

   assign flags.zero  = (sum == '0);
   assign flags.sign  = sum[W-1] ^ ovf; // signed less-than on rs - rt
   assign flags.carry = cout;

endmodule

// File: design/wordMem.sv
// word-addressed memory, synchronous write and asynchronous read
// payloadT picks the stored type, used for both instructions and data
`include "wisc_defs.svh"

module wordMem #(
   parameter type payloadT = logic [`WISC_WORD_W-1:0],
   parameter int  ADDR_W   = 8
) (
   input  logic              clk,
   input  logic              wrEn,
   input  logic [ADDR_W-1:0] wrAddr,
   input  payloadT           wrData,
   input  logic [ADDR_W-1:0] rdAddr,
   output payloadT           rdData
);

   payloadT mem [2**ADDR_W]; // contents undefined until written

   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[wrAddr] <= wrData;
      end
   end

   assign rdData = mem[rdAddr];

endmodule

// File: design/wiscCore.sv
// single-cycle WISC core: program loaded through the write port while idle,
// a run pulse starts at pc 0 and halted marks the end of the run
`include "wisc_defs.svh"

module wiscCore (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     loadEn,
   input  logic [`WISC_IADDR_W-1:0] loadAddr,
   input  wiscPkg::instrT           loadInstr,
   input  logic                     run,
   input  logic [2:0]               dbgRegSel,
   output wiscPkg::wordT            dbgRegData,
   input  logic [`WISC_DADDR_W-1:0] dbgMemAddr,
   output wiscPkg::wordT            dbgMemData,
   output wiscPkg::wordT            pc,
   output logic                     halted,
   output logic                     err
);

   localparam int W = `WISC_WORD_W;

   wiscPkg::instrT   instr;
   wiscPkg::ctrlT    ctrl;
   wiscPkg::flagsT   flags;
   wiscPkg::destSelT destSel;
   wiscPkg::wordT    rsData, rtData, bOperand, aluRes, memRd, wbData;
   wiscPkg::wordT    pcPlus1, nextPc, imm5Ext, imm8Ext, imm8Sext, imm11Sext;
   logic             illegal, running, condTrue;
   logic [2:0]       wrAddr;

   wordMem #(.payloadT(wiscPkg::instrT), .ADDR_W(`WISC_IADDR_W)) iMem (
      .clk(clk), .wrEn(loadEn && !running), .wrAddr(loadAddr), .wrData(loadInstr),
      .rdAddr(pc[`WISC_IADDR_W-1:0]), .rdData(instr));

   controlUnit ctrlUnit (.instr(instr), .ctrl(ctrl), .illegal(illegal));

   regFile regs (
      .clk(clk), .reset(reset), .rdAddrA(instr.rs), .rdAddrB(instr.rt),
      .rdDataA(rsData), .rdDataB(rtData), .wrEn(running && ctrl.regWrt),
      .wrAddr(wrAddr), .wrData(wbData), .dbgSel(dbgRegSel), .dbgData(dbgRegData));

   // immediates share the low instruction bits
   assign imm5Ext   = ctrl.zeroExt ? W'(instr.low) : {{(W-5){instr.low[4]}}, instr.low};
   assign imm8Sext  = {{(W-8){instr.rt[2]}}, instr.rt, instr.low};
   assign imm8Ext   = ctrl.zeroExt ? W'({instr.rt, instr.low}) : imm8Sext;
   assign imm11Sext = {{(W-11){instr.rs[2]}}, instr.rs, instr.rt, instr.low};

   always_comb begin
      case (ctrl.bSrc)
         wiscPkg::bImm5: bOperand = imm5Ext;
         wiscPkg::bImm8: bOperand = imm8Ext; // jr/jalr offset
         wiscPkg::bZero: bOperand = '0; // branch test of rs
         default:        bOperand = rtData;
      endcase
   end

   alu datapathAlu (.a(rsData), .b(bOperand), .ctrl(ctrl), .result(aluRes), .flags(flags));

   wordMem #(.payloadT(wiscPkg::wordT), .ADDR_W(`WISC_DADDR_W)) dMem (
      .clk(clk), .wrEn(running && ctrl.memWrt), .wrAddr(aluRes[`WISC_DADDR_W-1:0]),
      .wrData(rtData), .rdAddr(running ? aluRes[`WISC_DADDR_W-1:0] : dbgMemAddr),
      .rdData(memRd));

   assign dbgMemData = memRd; // valid while idle

   // one condition check for both branches and set ops
   always_comb begin
      case (ctrl.cond)
         wiscPkg::condZero:          condTrue = flags.zero;
         wiscPkg::condNonZero:       condTrue = !flags.zero;
         wiscPkg::condSign:          condTrue = flags.sign;
         wiscPkg::condNotSignOrZero: condTrue = !flags.sign || flags.zero;
         wiscPkg::condSignOrZero:    condTrue = flags.sign || flags.zero;
         wiscPkg::condCarry:         condTrue = flags.carry;
         wiscPkg::condAlways:        condTrue = 1'b1;
         default:                    condTrue = 1'b0;
      endcase
   end

   assign pcPlus1 = pc + W'(1);

   always_comb begin
      if (ctrl.jumpReg) nextPc = aluRes; // rs + sext imm8
      else if (ctrl.jumpImm) nextPc = pcPlus1 + imm11Sext;
      else if (condTrue && !ctrl.setOp) nextPc = pcPlus1 + imm8Sext; // taken branch
      else nextPc = pcPlus1;
   end

   always_comb begin
      case (ctrl.wbSel)
         wiscPkg::wbPcPlus: wbData = pcPlus1; // link value
         wiscPkg::wbMem:    wbData = memRd;
         wiscPkg::wbImm8:   wbData = ctrl.zeroExt ? ((rsData << 8) | imm8Ext) : imm8Sext;
         default:           wbData = ctrl.setOp ? W'(condTrue) : aluRes;
      endcase
   end

   // destination follows from the bundle, r-format ops read rt as a register
   always_comb begin
      if (ctrl.link) destSel = wiscPkg::destR7;
      else if (ctrl.stuSel || ctrl.wbSel == wiscPkg::wbImm8) destSel = wiscPkg::destRs;
      else if (ctrl.bSrc == wiscPkg::bReg) destSel = wiscPkg::destRd;
      else destSel = wiscPkg::destRt;
      case (destSel)
         wiscPkg::destRs: wrAddr = instr.rs;
         wiscPkg::destRd: wrAddr = instr.low[4:2];
         wiscPkg::destR7: wrAddr = 3'd7;
         default:         wrAddr = instr.rt;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc      <= '0;
         running <= 1'b0;
         halted  <= 1'b0;
         err     <= 1'b0;
      end else if (!running) begin
         if (run) begin // restart from word 0
            pc      <= '0;
            running <= 1'b1;
            halted  <= 1'b0;
            err     <= 1'b0;
         end
      end else if (ctrl.halt || illegal) begin
         running <= 1'b0; // pc holds
         halted  <= 1'b1;
         err     <= illegal;
      end else begin
         pc <= nextPc;
      end
   end

endmodule

// File: tb/wisc_chk.sv
// concurrent checks on the core's run/halt control, bound into every wiscCore
// failCount tallies broken rules, the testbench reads it for its verdict
module wiscChk (
   input logic        clk,
   input logic        reset,
   input logic        run,
   input logic        loadEn,
   input logic        running,
   input logic        halted,
   input logic        err,
   input logic [15:0] pc
);

   int failCount = 0; // broken rules so far

   // cleared state right after reset
   resetClears: assert property (@(posedge clk) reset |=> (!halted && !err))
      else begin
         $error("halted or err high in the cycle after reset");
         failCount++;
      end

   // stopped core keeps its pc unless a new run starts
   pcHolds: assert property (@(posedge clk) disable iff (reset)
      (halted && !run) |=> $stable(pc))
      else begin
         $error("pc moved while halted");
         failCount++;
      end

   errStops: assert property (@(posedge clk) disable iff (reset) err |-> halted)
      else begin
         $error("err set without halted");
         failCount++;
      end

   noLoadWhileRunning: assert property (@(posedge clk) disable iff (reset)
      !(loadEn && running))
      else begin
         $error("program load while the core was running");
         failCount++;
      end

endmodule

bind wiscCore wiscChk coreChk (
   .clk(clk), .reset(reset), .run(run), .loadEn(loadEn), .running(running),
   .halted(halted), .err(err), .pc(pc));

// File: tb/wiscTb.sv
// testbench for the WISC core: loads directed and random programs, runs them
// and checks registers, pc, err and a data memory window against wiscModel
`include "wisc_defs.svh"

module wiscTb;

   localparam int MEM_WIN  = 32; // data words compared per test
   localparam int MAX_WAIT = 4000; // cycles before a run counts as hung

   logic                     clk = 1'b0;
   logic                     reset, loadEn, run;
   logic [`WISC_IADDR_W-1:0] loadAddr;
   wiscPkg::instrT           loadInstr;
   logic [2:0]               dbgRegSel;
   logic [`WISC_DADDR_W-1:0] dbgMemAddr;
   wiscPkg::wordT            dbgRegData, dbgMemData, pc;
   logic                     halted, err;

   logic [15:0] prog [$]; // program under test
   logic [15:0] mRegs [`WISC_NREGS]; // model state, kept across tests like the core
   logic [15:0] mMem [256];
   logic        mWritten [256];
   logic [15:0] mPc;
   int          seed = 60;
   int          errors = 0, checks = 0, timeouts = 0, tests = 0, testErrs;

   wiscCore UUT (
      .clk(clk), .reset(reset), .loadEn(loadEn), .loadAddr(loadAddr),
      .loadInstr(loadInstr), .run(run), .dbgRegSel(dbgRegSel), .dbgRegData(dbgRegData),
      .dbgMemAddr(dbgMemAddr), .dbgMemData(dbgMemData), .pc(pc), .halted(halted),
      .err(err));

   always #2 clk = ~clk;

   function automatic logic [15:0] iForm(logic [4:0] op, logic [2:0] rs, logic [2:0] rt,
                                         logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [15:0] rForm(logic [4:0] op, logic [2:0] rs, logic [2:0] rt,
                                         logic [2:0] rd, logic [1:0] fn);
      return {op, rs, rt, rd, fn};
   endfunction

   function automatic logic [15:0] bForm(logic [4:0] op, logic [2:0] rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   // kind 0 rol, 1 sll, 2 ror, 3 srl
   function automatic logic [15:0] shiftVal(logic [1:0] kind, logic [15:0] v,
                                            logic [3:0] amt);
      logic [31:0] wide;
      wide = {v, v};
      case (kind)
         2'd0:    return (wide << amt) >> 16;
         2'd1:    return v << amt;
         2'd2:    return wide >> amt; // low half
         default: return v >> amt;
      endcase
   endfunction

   // ISA interpreter over prog, returns the err bit and leaves the final pc in mPc
   function automatic logic wiscModel();
      logic [15:0] pcv, in, npc, a, b, addr;
      logic [4:0]  op;
      logic [2:0]  rs, rt, rd;
      logic [1:0]  fn;
      logic [16:0] wideSum;
      pcv = '0;
      for (int step = 0; step < 2000; step++) begin
         in  = prog[pcv[7:0]];
         op  = in[15:11];
         rs  = in[10:8];
         rt  = in[7:5];
         rd  = in[4:2];
         fn  = in[1:0];
         a   = mRegs[rs];
         b   = mRegs[rt];
         npc = pcv + 16'd1;
         addr = a + {{11{in[4]}}, in[4:0]}; // rs + sext imm5
         case (op)
            5'd0: begin
               mPc = pcv;
               return 1'b0;
            end
            5'd1, 5'd2, 5'd3: ; // nop, siic, rti
            5'd4: npc = npc + {{5{in[10]}}, in[10:0]};
            5'd5: npc = a + {{8{in[7]}}, in[7:0]};
            5'd6: begin
               mRegs[7] = npc;
               npc = npc + {{5{in[10]}}, in[10:0]};
            end
            5'd7: begin
               mRegs[7] = npc;
               npc = a + {{8{in[7]}}, in[7:0]};
            end
            5'd8:  mRegs[rt] = addr;
            5'd9:  mRegs[rt] = {{11{in[4]}}, in[4:0]} - a; // imm minus rs
            5'd10: mRegs[rt] = a ^ {11'd0, in[4:0]};
            5'd11: mRegs[rt] = a & ~{11'd0, in[4:0]};
            5'd12: if (a == 0) npc = npc + {{8{in[7]}}, in[7:0]};
            5'd13: if (a != 0) npc = npc + {{8{in[7]}}, in[7:0]};
            5'd14: if (a[15]) npc = npc + {{8{in[7]}}, in[7:0]};
            5'd15: if (!a[15]) npc = npc + {{8{in[7]}}, in[7:0]};
            5'd16: begin
               mMem[addr[7:0]] = b;
               mWritten[addr[7:0]] = 1'b1;
            end
            5'd17: mRegs[rt] = mMem[addr[7:0]];
            5'd18: mRegs[rs] = (a << 8) | {8'd0, in[7:0]};
            5'd19: begin
               mMem[addr[7:0]] = b;
               mWritten[addr[7:0]] = 1'b1;
               mRegs[rs] = addr; // base update
            end
            5'd20, 5'd21, 5'd22, 5'd23: mRegs[rt] = shiftVal(op[1:0], a, in[3:0]);
            5'd24: mRegs[rs] = {{8{in[7]}}, in[7:0]};
            5'd26: mRegs[rd] = shiftVal(fn, a, b[3:0]);
            5'd27: begin
               case (fn)
                  2'd0: mRegs[rd] = a + b;
                  2'd1: mRegs[rd] = b - a;
                  2'd2: mRegs[rd] = a ^ b;
                  default: mRegs[rd] = a & ~b;
               endcase
            end
            5'd28: mRegs[rd] = {15'd0, a == b};
            5'd29: mRegs[rd] = {15'd0, $signed(a) < $signed(b)};
            5'd30: mRegs[rd] = {15'd0, $signed(a) <= $signed(b)};
            5'd31: begin
               wideSum = {1'b0, a} + {1'b0, b};
               mRegs[rd] = {15'd0, wideSum[16]};
            end
            default: begin // illegal, stop before any write
               mPc = pcv;
               return 1'b1;
            end
         endcase
         pcv = npc;
      end
      mPc = pcv;
      return 1'b0;
   endfunction

   task automatic checkValue(string name, logic [15:0] expected, logic [15:0] actual);
      checks++;
      if (expected !== actual) begin
         $display("FAILED %s expected %h actual %h", name, expected, actual);
         errors++;
         testErrs++;
      end
   endtask

   task automatic emit(logic [15:0] word);
      prog.push_back(word);
   endtask

   // load prog, run it, then compare the debug view with the model
   task automatic runTest(string name);
      int   waited;
      logic expErr;
      testErrs = 0;
      tests++;
      foreach (prog[i]) begin
         @(posedge clk);
         loadEn    <= 1'b1;
         loadAddr  <= i[`WISC_IADDR_W-1:0];
         loadInstr <= prog[i];
      end
      @(posedge clk);
      loadEn <= 1'b0;
      run    <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      waited = 0;
      @(negedge clk);
      while (!halted && waited < MAX_WAIT) begin
         @(negedge clk);
         waited++;
      end
      if (!halted) begin
         $display("%s: core never halted within %0d cycles", name, MAX_WAIT);
         timeouts++;
         prog.delete();
         return;
      end
      expErr = wiscModel();
      checkValue({name, " err"}, {15'd0, expErr}, {15'd0, err});
      checkValue({name, " pc"}, mPc, pc);
      for (int r = 0; r < `WISC_NREGS; r++) begin
         @(posedge clk);
         dbgRegSel <= r[2:0];
         @(negedge clk);
         checkValue($sformatf("%s r%0d", name, r), mRegs[r], dbgRegData);
      end
      for (int m = 0; m < MEM_WIN; m++) begin
         @(posedge clk);
         dbgMemAddr <= m[`WISC_DADDR_W-1:0];
         @(negedge clk);
         if (mWritten[m]) checkValue($sformatf("%s mem[%0d]", name, m), mMem[m], dbgMemData);
      end
      $display("%s: done, %0d mismatches", name, testErrs);
      prog.delete();
   endtask

   initial begin
      logic [31:0] v;
      logic [4:0]  op;
      reset      = 1'b1;
      loadEn     = 1'b0;
      run        = 1'b0;
      loadAddr   = '0;
      loadInstr  = '0;
      dbgRegSel  = '0;
      dbgMemAddr = '0;
      foreach (mRegs[i]) mRegs[i] = '0;
      foreach (mMem[i]) begin
         mMem[i] = '0;
         mWritten[i] = 1'b0;
      end
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      // arithmetic and logic, immediate and register forms
      emit(bForm(5'd24, 3'd1, 8'h35));
      emit(bForm(5'd24, 3'd2, 8'hF9));
      emit(bForm(5'd18, 3'd2, 8'h12));
      emit(iForm(5'd8, 3'd1, 3'd3, 5'h1D));
      emit(iForm(5'd9, 3'd1, 3'd4, 5'd5));
      emit(iForm(5'd10, 3'd2, 3'd5, 5'h1B));
      emit(iForm(5'd11, 3'd2, 3'd6, 5'h0F));
      emit(rForm(5'd27, 3'd1, 3'd2, 3'd7, 2'd0));
      emit(rForm(5'd27, 3'd1, 3'd2, 3'd3, 2'd1));
      emit(rForm(5'd27, 3'd1, 3'd2, 3'd4, 2'd2));
      emit(rForm(5'd27, 3'd2, 3'd1, 3'd5, 2'd3));
      emit(16'h0000);
      runTest("arith");

      // every immediate shift kind and amount, results folded into r7
      emit(bForm(5'd24, 3'd1, 8'h5A));
      emit(bForm(5'd18, 3'd1, 8'hC3));
      emit(bForm(5'd24, 3'd7, 8'h00));
      for (int k = 0; k < 64; k++) begin
         emit(iForm(5'd20 + 5'(k / 16), 3'd1, 3'd2, 5'(k % 16)));
         emit(iForm(5'd20, 3'd7, 3'd7, 5'd1)); // fold depends on order
         emit(rForm(5'd27, 3'd7, 3'd2, 3'd7, 2'd2));
      end
      emit(16'h0000);
      runTest("shiftImm");

      // register shift forms, amount in r3
      emit(bForm(5'd24, 3'd7, 8'h00));
      for (int k = 0; k < 16; k++) begin
         emit(bForm(5'd24, 3'd3, 8'(k)));
         for (int f = 0; f < 4; f++) begin
            emit(rForm(5'd26, 3'd1, 3'd3, 3'd4, 2'(f)));
            emit(iForm(5'd20, 3'd7, 3'd7, 5'd1));
            emit(rForm(5'd27, 3'd7, 3'd4, 3'd7, 2'd2));
         end
      end
      emit(16'h0000);
      runTest("shiftReg");

      // ST, STU and LD through data memory
      emit(bForm(5'd24, 3'd1, 8'd4));
      emit(bForm(5'd24, 3'd2, 8'h77));
      emit(bForm(5'd18, 3'd2, 8'h11));
      emit(iForm(5'd16, 3'd1, 3'd2, 5'd3));
      emit(iForm(5'd19, 3'd1, 3'd2, 5'h1E)); // r1 becomes 2
      emit(iForm(5'd17, 3'd1, 3'd3, 5'd5));
      emit(iForm(5'd8, 3'd2, 3'd2, 5'd1));
      emit(iForm(5'd16, 3'd1, 3'd2, 5'd0));
      emit(iForm(5'd17, 3'd1, 3'd4, 5'd0));
      emit(16'h0000);
      runTest("memory");

      // set ops, then branches over marker instructions
      emit(bForm(5'd24, 3'd1, 8'hFD));
      emit(bForm(5'd24, 3'd2, 8'd5));
      emit(rForm(5'd28, 3'd1, 3'd2, 3'd3, 2'd0));
      emit(rForm(5'd29, 3'd1, 3'd2, 3'd4, 2'd0));
      emit(rForm(5'd30, 3'd2, 3'd2, 3'd5, 2'd0));
      emit(rForm(5'd31, 3'd1, 3'd2, 3'd6, 2'd0));
      emit(bForm(5'd24, 3'd7, 8'd0));
      emit(bForm(5'd12, 3'd7, 8'd1));
      emit(bForm(5'd24, 3'd3, 8'h11));
      emit(bForm(5'd13, 3'd1, 8'd1));
      emit(bForm(5'd24, 3'd4, 8'h22));
      emit(bForm(5'd14, 3'd2, 8'd1)); // not taken
      emit(iForm(5'd8, 3'd7, 3'd7, 5'd1)); // markers add a bit each to r7
      emit(bForm(5'd15, 3'd2, 8'd1));
      emit(bForm(5'd24, 3'd6, 8'h44));
      emit(bForm(5'd14, 3'd1, 8'd1));
      emit(bForm(5'd24, 3'd6, 8'h55));
      emit(bForm(5'd12, 3'd1, 8'd1)); // not taken
      emit(iForm(5'd8, 3'd7, 3'd7, 5'd2));
      emit(bForm(5'd13, 3'd3, 8'd1)); // not taken, r3 is 0
      emit(iForm(5'd8, 3'd7, 3'd7, 5'd4));
      emit(bForm(5'd15, 3'd1, 8'd1)); // not taken
      emit(iForm(5'd8, 3'd7, 3'd7, 5'd8));
      emit(16'h0000);
      runTest("compare");

      // jumps and links
      emit(bForm(5'd24, 3'd1, 8'd6));
      emit({5'd4, 11'd1});
      emit(bForm(5'd24, 3'd2, 8'h11));
      emit({5'd6, 11'd1});
      emit(bForm(5'd24, 3'd3, 8'h22));
      emit(bForm(5'd5, 3'd1, 8'd2));
      emit(bForm(5'd24, 3'd4, 8'h33));
      emit(16'h0000);
      emit(iForm(5'd8, 3'd7, 3'd5, 5'd0)); // r5 keeps the JAL link
      emit(bForm(5'd7, 3'd1, 8'd4));
      emit(16'h0000);
      runTest("jumps");

      // error stop on 11001
      emit(bForm(5'd24, 3'd1, 8'h21));
      emit(iForm(5'd8, 3'd1, 3'd2, 5'd3));
      emit(16'hC800);
      emit(bForm(5'd24, 3'd1, 8'h99));
      emit(16'h0000);
      runTest("illegal");

      for (int p = 0; p < 4; p++) begin
         for (int r = 0; r < 8; r++) begin
            v = $random(seed);
            emit(bForm(5'd24, r[2:0], v[7:0]));
         end
         for (int n = 0; n < 24; n++) begin
            v = $random(seed);
            case (v[2:0])
               3'd0:    op = 5'd8 + 5'(v[4:3]);
               3'd1:    op = 5'd20 + 5'(v[4:3]);
               3'd2:    op = 5'd26;
               3'd3:    op = 5'd28 + 5'(v[4:3]);
               3'd4:    op = 5'd18;
               default: op = 5'd27;
            endcase
            emit({op, v[15:5]});
         end
         emit(16'h0000);
         runTest($sformatf("random%0d", p));
      end

      $display("%0d tests, %0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
               tests, checks, errors, timeouts, UUT.coreChk.failCount);
      if (errors == 0 && timeouts == 0 && UUT.coreChk.failCount == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: all.f
+incdir+design
design/wiscPkg.sv
design/controlUnit.sv
design/regFile.sv
design/alu.sv
design/wordMem.sv
design/wiscCore.sv
tb/wisc_chk.sv
tb/wiscTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator and run; exit status follows the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module wiscTb -o wiscSim &&
./obj_dir/wiscSim | awk '{print} /Regression passed/{ok=1} END{exit !ok}' ||
exit 1
